/* all.f */
hw/msx_pkg.sv
hw/msx_cpu_bus_ctrl.sv
hw/msx_ppi.sv
hw/msx_keyboard.sv
hw/msx_slot_map.sv
hw/msx_audio_mix.sv
hw/msx_core.sv
tests/msx_asserts.sv
tests/msx_tb.sv

/* hw/msx_audio_mix.sv */
`timescale 1ns/100ps
`default_nettype none

module msx_audio_mix
   import msx_pkg::*;
(
   input  wire logic               clock_bus,
   input  wire logic               reset,
   input  wire logic               keyclick,
   input  wire logic               tape_in,
   input  wire logic               motor,
   input  wire logic signed [15:0] ext_sound,
   output logic signed [15:0]      audio
);

   logic signed [16:0] click_term;
   logic signed [16:0] tape_term;
   logic signed [16:0] sum;
   logic signed [15:0] sat;

   assign click_term = keyclick ? signed'({1'b0, KEYCLICK_LEVEL}) : 17'sd0;
   // Tape is only heard while the motor relay is off
   assign tape_term  = (tape_in && !motor) ? signed'({1'b0, TAPE_LEVEL}) : 17'sd0;
   assign sum        = signed'({ext_sound[15], ext_sound}) + click_term + tape_term;

   // Top two bits differ on overflow, sign bit gives the direction
   always_comb begin
      if (sum[16] != sum[15]) begin
         sat = sum[16] ? 16'sh8000 : 16'sh7FFF;
      end else begin
         sat = sum[15:0];
      end
   end

   always_ff @(posedge clock_bus) begin
      if (reset) begin
         audio <= 16'sd0;
      end else begin
         audio <= sat;
      end
   end

endmodule

`default_nettype wire

/* hw/msx_core.sv */
`timescale 1ns/100ps
`default_nettype none

module msx_core
   import msx_pkg::*;
(
   input  wire logic               clock_bus,
   input  wire logic               reset,
   input  wire logic               cpu_ce,
   input  wire cpu_bus_t           cpu_bus,
   input  wire logic               m1,
   input  wire logic               mreq,
   input  wire key_event_t         key_ev,
   input  wire logic [7:0]         ram_dout,
   input  wire logic               tape_in,
   input  wire logic signed [15:0] ext_sound,
   output logic [7:0]              cpu_din,
   output logic                    wait_n,
   output mem_req_t                mem,
   output logic                    tape_motor_on,
   output logic signed [15:0]      audio
);

   logic       ppi_cs;
   logic [7:0] ppi_dout;
   logic [7:0] port_a;
   logic [7:0] port_c;
   logic [7:0] row_data;

   // Cassette relay on PPI C4
   assign tape_motor_on = port_c[4];

   msx_cpu_bus_ctrl bus_ctrl0 (
      .clock_bus (clock_bus),
      .reset     (reset),
      .cpu_ce    (cpu_ce),
      .cpu_bus   (cpu_bus),
      .m1        (m1),
      .mreq      (mreq),
      .ppi_dout  (ppi_dout),
      .ram_dout  (ram_dout),
      .ppi_cs    (ppi_cs),
      .wait_n    (wait_n),
      .cpu_din   (cpu_din)
   );

   msx_ppi ppi0 (
      .clock_bus (clock_bus),
      .reset     (reset),
      .cs        (ppi_cs),
      .cpu_bus   (cpu_bus),
      .port_b_in (row_data),
      .dout      (ppi_dout),
      .port_a    (port_a),
      .port_c    (port_c)
   );

   // Row select on C3..C0, columns back on port B
   msx_keyboard keyboard0 (
      .clock_bus (clock_bus),
      .reset     (reset),
      .key_ev    (key_ev),
      .row_sel   (port_c[3:0]),
      .row_data  (row_data)
   );

   msx_slot_map slot_map0 (
      .cpu_bus (cpu_bus),
      .mreq    (mreq),
      .port_a  (port_a),
      .mem     (mem)
   );

   // Keyclick on C7
   msx_audio_mix audio_mix0 (
      .clock_bus (clock_bus),
      .reset     (reset),
      .keyclick  (port_c[7]),
      .tape_in   (tape_in),
      .motor     (port_c[4]),
      .ext_sound (ext_sound),
      .audio     (audio)
   );

endmodule

`default_nettype wire

/* hw/msx_cpu_bus_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module msx_cpu_bus_ctrl
   import msx_pkg::*;
(
   input  wire logic       clock_bus,
   input  wire logic       reset,
   input  wire logic       cpu_ce,
   input  wire cpu_bus_t   cpu_bus,
   input  wire logic       m1,
   input  wire logic       mreq,
   input  wire logic [7:0] ppi_dout,
   input  wire logic [7:0] ram_dout,
   output logic            ppi_cs,
   output logic            wait_n,
   output logic [7:0]      cpu_din
);

   // Set while the current fetch has not been stretched yet
   logic armed;

   // PPI sits at 0xA8-0xAB, interrupt acknowledge excluded
   assign ppi_cs = cpu_bus.iorq & ~m1 & (cpu_bus.addr[7:3] == PPI_PORT_BASE);

   // M1 wait generator
   // One cpu_ce period of wait per opcode fetch
   always_ff @(posedge clock_bus) begin
      if (reset) begin
         wait_n <= 1'b1;
         armed  <= 1'b1;
      end else begin
         if (!m1) begin
            armed <= 1'b1;
         end
         if (cpu_ce) begin
            if (!wait_n) begin
               wait_n <= 1'b1;
            end else if (m1 && armed) begin
               // Fetch seen, hold the CPU until the next strobe
               wait_n <= 1'b0;
               armed  <= 1'b0;
            end
         end
      end
   end

   // Read data mux, PPI first, then memory, idle bus floats high
   always_comb begin
      if (ppi_cs && cpu_bus.rd) begin
         cpu_din = ppi_dout;
      end else if (mreq && cpu_bus.rd) begin
         cpu_din = ram_dout;
      end else begin
         cpu_din = 8'hFF;
      end
   end

endmodule

`default_nettype wire

/* hw/msx_keyboard.sv */
`timescale 1ns/100ps
`default_nettype none

module msx_keyboard
   import msx_pkg::*;
(
   input  wire logic       clock_bus,
   input  wire logic       reset,
   input  wire key_event_t key_ev,
   input  wire logic [3:0] row_sel,
   output logic [7:0]      row_data
);

   // One byte per row, a cleared bit is a pressed key
   logic [7:0] matrix [KEY_ROWS];

   logic ev_row_ok;
   logic sel_row_ok;

   // Rows 11 to 15 do not exist on the MSX matrix
   assign ev_row_ok  = key_ev.row < 4'(KEY_ROWS);
   assign sel_row_ok = row_sel < 4'(KEY_ROWS);

   always_ff @(posedge clock_bus) begin
      if (reset) begin
         for (int r = 0; r < KEY_ROWS; r++) begin
            matrix[r] <= 8'hFF;
         end
      end else if (key_ev.valid && ev_row_ok) begin
         matrix[key_ev.row][key_ev.col] <= ~key_ev.pressed;
      end
   end

   // Row scan through port C low nibble
   always_comb begin
      if (sel_row_ok) begin
         row_data = matrix[row_sel];
      end else begin
         row_data = 8'hFF;
      end
   end

endmodule

`default_nettype wire

/* hw/msx_pkg.sv */
`default_nettype none

package msx_pkg;

   // I/O prefix of the PPI ports 0xA8 to 0xAB
   localparam logic [4:0] PPI_PORT_BASE = 5'b10101;

   // Port A out, port B in, port C out
   localparam logic [7:0] PPI_CTRL_RESET = 8'h82;

   // Keyboard matrix height
   localparam int KEY_ROWS = 11;

   // Fixed audio levels for keyclick and tape input
   localparam logic [15:0] KEYCLICK_LEVEL = 16'h0800;
   localparam logic [15:0] TAPE_LEVEL = 16'h0400;

   // Flat Z80 bus as seen by the core
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  dout;
      logic        rd;
      logic        wr;
      logic        iorq;
   } cpu_bus_t;

   // External memory request, slot in the top two address bits
   typedef struct packed {
      logic [17:0] addr;
      logic [7:0]  din;
      logic        ce;
      logic        rnw;
   } mem_req_t;

   // Decoded key press or release
   typedef struct packed {
      logic       valid;
      logic       pressed;
      logic [3:0] row;
      logic [2:0] col;
   } key_event_t;

   // 8255 mode word, direction bits are 1 for input
   typedef struct packed {
      logic       flag;
      logic [1:0] grp_a_mode;
      logic       port_a_in;
      logic       port_c_hi_in;
      logic       grp_b_mode;
      logic       port_b_in;
      logic       port_c_lo_in;
   } ppi_mode_t;

   // 8255 bit set/reset command on port C
   typedef struct packed {
      logic       flag;
      logic [2:0] unused;
      logic [2:0] bit_sel;
      logic       value;
   } ppi_bsr_t;

   // Bit 7 tells which view applies
   typedef union packed {
      ppi_mode_t mode;
      ppi_bsr_t  bsr;
   } ppi_ctrl_u;

endpackage

`default_nettype wire

/* hw/msx_ppi.sv */
`timescale 1ns/100ps
`default_nettype none

module msx_ppi
   import msx_pkg::*;
(
   input  wire logic       clock_bus,
   input  wire logic       reset,
   input  wire logic       cs,
   input  wire cpu_bus_t   cpu_bus,
   input  wire logic [7:0] port_b_in,
   output logic [7:0]      dout,
   output logic [7:0]      port_a,
   output logic [7:0]      port_c
);

   ppi_ctrl_u  ctrl;
   ppi_ctrl_u  wdata;
   logic [7:0] port_b_latch;
   logic       wr_q;
   logic       wr_stb;

   // CPU data viewed as a control word
   assign wdata = ppi_ctrl_u'(cpu_bus.dout);

   // Write acts only on the first clock of wr
   assign wr_stb = cs & cpu_bus.wr & ~wr_q;

   always_ff @(posedge clock_bus) begin
      if (reset) begin
         wr_q <= 1'b0;
      end else begin
         wr_q <= cpu_bus.wr;
      end
   end

   always_ff @(posedge clock_bus) begin
      if (reset) begin
         ctrl         <= ppi_ctrl_u'(PPI_CTRL_RESET);
         port_a       <= 8'h00;
         port_b_latch <= 8'h00;
         port_c       <= 8'h00;
      end else if (wr_stb) begin
         case (cpu_bus.addr[1:0])
            2'd0: begin
               port_a <= cpu_bus.dout;
            end
            2'd1: begin
               port_b_latch <= cpu_bus.dout;
            end
            2'd2: begin
               port_c <= cpu_bus.dout;
            end
            default: begin
               if (wdata.mode.flag) begin
                  // New mode word resets all outputs
                  ctrl         <= wdata;
                  port_a       <= 8'h00;
                  port_b_latch <= 8'h00;
                  port_c       <= 8'h00;
               end else begin
                  port_c[wdata.bsr.bit_sel] <= wdata.bsr.value;
               end
            end
         endcase
      end
   end

   // Register read back
   always_comb begin
      case (cpu_bus.addr[1:0])
         2'd0: begin
            dout = port_a;
         end
         2'd1: begin
            // Keyboard columns when B is an input
            dout = ctrl.mode.port_b_in ? port_b_in : port_b_latch;
         end
         2'd2: begin
            dout = port_c;
         end
         default: begin
            dout = ctrl;
         end
      endcase
   end

endmodule

`default_nettype wire

/* hw/msx_slot_map.sv */
`timescale 1ns/100ps
`default_nettype none

module msx_slot_map
   import msx_pkg::*;
(
   input  wire cpu_bus_t   cpu_bus,
   input  wire logic       mreq,
   input  wire logic [7:0] port_a,
   output mem_req_t        mem
);

   logic [1:0] active_slot;

   // Port A holds two slot bits per 16 KB page
   always_comb begin
      case (cpu_bus.addr[15:14])
         2'b00: begin
            active_slot = port_a[1:0];
         end
         2'b01: begin
            active_slot = port_a[3:2];
         end
         2'b10: begin
            active_slot = port_a[5:4];
         end
         default: begin
            active_slot = port_a[7:6];
         end
      endcase
   end

   // Request toward external memory
   always_comb begin
      mem.addr = {active_slot, cpu_bus.addr};
      mem.din  = cpu_bus.dout;
      mem.ce   = mreq & (cpu_bus.rd | cpu_bus.wr);
      mem.rnw  = ~cpu_bus.wr;
   end

endmodule

`default_nettype wire

/* tests/msx_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module msx_asserts (
   input wire logic clock_bus,
   input wire logic reset,
   input wire logic cpu_ce,
   input wire logic m1,
   input wire logic ppi_cs,
   input wire logic wait_n
);

   // CPU runs freely out of reset
   assert property (@(posedge clock_bus) reset |=> wait_n)
      else $error("wait_n low after a reset clock");

   // A wait only starts at a strobe
   assert property (@(posedge clock_bus) disable iff (reset) $fell(wait_n) |-> $past(cpu_ce))
      else $error("wait_n fell without a cpu_ce strobe");

   // Released at the following strobe
   assert property (@(posedge clock_bus) disable iff (reset) (!wait_n && cpu_ce) |=> wait_n)
      else $error("wait_n held past the second cpu_ce strobe");

   // Interrupt acknowledge never reaches the PPI
   assert property (@(posedge clock_bus) disable iff (reset) m1 |-> !ppi_cs)
      else $error("ppi_cs active during an M1 cycle");

endmodule

bind msx_cpu_bus_ctrl msx_asserts asserts0 (
   .clock_bus (clock_bus),
   .reset     (reset),
   .cpu_ce    (cpu_ce),
   .m1        (m1),
   .ppi_cs    (ppi_cs),
   .wait_n    (wait_n)
);

`default_nettype wire

/* tests/msx_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module msx_tb
   import msx_pkg::*;
();

   logic clock_bus, reset, cpu_ce, m1, mreq, tape_in, wait_n, tape_motor_on;
   logic [1:0] ce_cnt;
   cpu_bus_t cpu_bus;
   key_event_t key_ev;
   mem_req_t mem;
   logic [7:0] ram_dout, cpu_din;
   logic signed [15:0] ext_sound, audio;
   int errors, checks, timeouts;

   // Reference state of the PPI and the key matrix
   ppi_ctrl_u m_ctrl;
   logic [7:0] m_port_a, m_port_b, m_port_c;
   logic [7:0] m_keys [KEY_ROWS];

   msx_core dut0 (
      .clock_bus (clock_bus), .reset (reset), .cpu_ce (cpu_ce), .cpu_bus (cpu_bus),
      .m1 (m1), .mreq (mreq), .key_ev (key_ev), .ram_dout (ram_dout),
      .tape_in (tape_in), .ext_sound (ext_sound), .cpu_din (cpu_din),
      .wait_n (wait_n), .mem (mem), .tape_motor_on (tape_motor_on), .audio (audio)
   );

   always #50 clock_bus = ~clock_bus;

   // cpu_ce on every 4th clock
   always @(posedge clock_bus) begin
      ce_cnt <= ce_cnt + 2'd1;
      cpu_ce <= (ce_cnt == 2'd3);
   end

   task automatic check(input string name, input logic [17:0] exp, input logic [17:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[ERROR] %s expected %h actual %h", name, exp, act);
      end
   endtask

   function automatic logic [7:0] exp_io(input logic [7:0] addr);
      logic [3:0] row;
      row = m_port_c[3:0];
      if (addr[7:3] != PPI_PORT_BASE) return 8'hFF;
      case (addr[1:0])
         2'd0: return m_port_a;
         2'd1: begin
            // Latch when B is an output, otherwise the scanned row
            if (!m_ctrl.mode.port_b_in) return m_port_b;
            return (row < KEY_ROWS) ? m_keys[row] : 8'hFF;
         end
         2'd2: return m_port_c;
         default: return m_ctrl;
      endcase
   endfunction

   function automatic logic [15:0] mix_model(input int ext, input logic kc, input logic tape,
                                             input logic motor);
      int s;
      s = ext;
      if (kc) s += 2048;
      if (tape && !motor) s += 1024;
      if (s > 32767) s = 32767;
      if (s < -32768) s = -32768;
      return s[15:0];
   endfunction

   // Holds the bus for 4 clocks and returns at the sample point of the last one
   task automatic drive_bus(input logic [15:0] addr, input logic [7:0] data, input logic rd,
                            input logic wr, input logic iorq, input logic mreq_v,
                            input logic [7:0] rdat);
      cpu_bus_t b;
      b.addr = addr;
      b.dout = data;
      b.rd = rd;
      b.wr = wr;
      b.iorq = iorq;
      @(posedge clock_bus);
      cpu_bus <= b;
      mreq <= mreq_v;
      ram_dout <= rdat;
      repeat (3) @(posedge clock_bus);
      @(negedge clock_bus);
   endtask

   task automatic release_bus();
      @(posedge clock_bus);
      cpu_bus <= '0;
      mreq <= 1'b0;
      m1 <= 1'b0;
   endtask

   task automatic io_write(input logic [7:0] addr, input logic [7:0] data);
      ppi_ctrl_u w;
      w = ppi_ctrl_u'(data);
      drive_bus({8'h00, addr}, data, 1'b0, 1'b1, 1'b1, 1'b0, 8'h00);
      release_bus();
      case (addr[1:0])
         2'd0: m_port_a = data;
         2'd1: m_port_b = data;
         2'd2: m_port_c = data;
         default: begin
            if (w.mode.flag) begin
               m_ctrl = w;
               m_port_a = 8'h00;
               m_port_b = 8'h00;
               m_port_c = 8'h00;
            end else begin
               m_port_c[w.bsr.bit_sel] = w.bsr.value;
            end
         end
      endcase
   endtask

   task automatic io_read(input string name, input logic [7:0] addr);
      drive_bus({8'h00, addr}, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0, 8'h5A);
      check(name, exp_io(addr), cpu_din);
      check("io_mem_ce", 0, mem.ce);
      release_bus();
   endtask

   task automatic key_event(input logic pressed, input logic [3:0] row, input logic [2:0] col);
      key_event_t ev;
      ev.valid = 1'b1;
      ev.pressed = pressed;
      ev.row = row;
      ev.col = col;
      @(posedge clock_bus);
      key_ev <= ev;
      @(posedge clock_bus);
      key_ev <= '0;
      if (row < KEY_ROWS) m_keys[row][col] = !pressed;
   endtask

   // Opcode fetch held until the wait state is over
   task automatic m1_fetch();
      cpu_bus_t b;
      int n;
      int low;
      b = '0;
      b.addr = 16'($urandom);
      b.rd = 1'b1;
      @(posedge clock_bus);
      cpu_bus <= b;
      mreq <= 1'b1;
      m1 <= 1'b1;
      @(negedge clock_bus);
      for (n = 0; n < 20 && wait_n; n++) @(negedge clock_bus);
      if (wait_n) begin
         timeouts++;
         $display("Timeout: wait_n never went low on an M1 fetch");
      end
      for (low = 0; low < 20 && !wait_n; low++) @(negedge clock_bus);
      if (!wait_n) begin
         timeouts++;
         $display("Timeout: wait_n stuck low on an M1 fetch");
      end
      check("m1_wait_clocks", 4, low);
      release_bus();
      repeat (2) @(posedge clock_bus);
   endtask

   initial begin
      logic [15:0] a16;
      logic [7:0] a, d, rdat;
      logic [1:0] slot;
      logic wr_v, kc, mot, tp;
      logic signed [15:0] e;
      clock_bus = 1'b0;
      reset = 1'b1;
      cpu_ce = 1'b0;
      ce_cnt = 2'd0;
      m1 = 1'b0;
      mreq = 1'b0;
      tape_in = 1'b0;
      cpu_bus = '0;
      key_ev = '0;
      ram_dout = 8'h00;
      ext_sound = 16'sd0;
      errors = 0;
      checks = 0;
      timeouts = 0;
      a16 = 16'($urandom(77));
      m_ctrl = ppi_ctrl_u'(PPI_CTRL_RESET);
      m_port_a = 8'h00;
      m_port_b = 8'h00;
      m_port_c = 8'h00;
      for (int r = 0; r < KEY_ROWS; r++) m_keys[r] = 8'hFF;
      repeat (3) @(posedge clock_bus);
      reset <= 1'b0;

      @(negedge clock_bus);
      check("reset_mem_ce", 0, mem.ce);
      check("reset_audio", 0, $unsigned(audio));
      check("reset_wait_n", 1, wait_n);
      io_read("reset_port_a", 8'hA8);
      io_read("reset_port_c", 8'hAA);
      io_read("reset_ctrl", 8'hAB);
      for (int r = 0; r < KEY_ROWS; r++) begin
         io_write(8'hAA, 8'(r));
         io_read("reset_row", 8'hA9);
      end

      // Random byte on 0xAB covers mode words and bit set/reset alike
      repeat (40) begin
         a = 8'hA8 + 8'($urandom_range(3));
         io_write(a, 8'($urandom));
         check("tape_motor_on", m_port_c[4], tape_motor_on);
         io_read("ppi_readback", a);
      end

      io_write(8'hAB, PPI_CTRL_RESET);
      repeat (20) begin
         repeat (3) key_event(1'($urandom), 4'($urandom), 3'($urandom));
         io_write(8'hAA, {4'h0, 4'($urandom)});
         io_read("key_row", 8'hA9);
      end

      repeat (30) begin
         io_write(8'hA8, 8'($urandom));
         a16 = 16'($urandom);
         d = 8'($urandom);
         rdat = 8'($urandom);
         wr_v = 1'($urandom);
         drive_bus(a16, d, !wr_v, wr_v, 1'b0, 1'b1, rdat);
         slot = 2'(m_port_a >> (2 * a16[15:14]));
         check("mem_addr", {slot, a16}, mem.addr);
         check("mem_ce", 1, mem.ce);
         check("mem_rnw", !wr_v, mem.rnw);
         check("mem_din", d, mem.din);
         check("mem_cpu_din", wr_v ? 8'hFF : rdat, cpu_din);
         release_bus();
      end
      repeat (8) begin
         a = 8'($urandom);
         if (a[7:3] == PPI_PORT_BASE) a = a ^ 8'h40;
         io_read("io_unmapped", a);
      end

      repeat (6) m1_fetch();

      repeat (30) begin
         kc = 1'($urandom);
         mot = 1'($urandom);
         tp = 1'($urandom);
         case ($urandom_range(3))
            0: e = 16'sh7FFF;
            1: e = 16'sh8000;
            2: e = 16'sh7FFF - 16'($urandom_range(3000));
            default: e = 16'($urandom);
         endcase
         io_write(8'hAB, {4'h0, 3'd7, kc});
         io_write(8'hAB, {4'h0, 3'd4, mot});
         @(posedge clock_bus);
         ext_sound <= e;
         tape_in <= tp;
         @(posedge clock_bus);
         @(negedge clock_bus);
         check("audio_mix", mix_model(int'(e), kc, tp, mot), $unsigned(audio));
      end

      $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
